// ==== source/divPkg.sv ====
// shared definitions for the division unit
// word, FIFO and counter widths, serial divider latency
// divider state and result path enums
// reciprocal table for the constant-divisor engine
`default_nettype none

package divPkg;

	// ====================
	// widths and depths
	// ====================
	localparam int WIDTH = 32;
	localparam int FIFO_DEPTH = 4;
	localparam int COUNT_WIDTH = 16;
	// one load edge plus one edge per quotient bit
	localparam int SLOW_LATENCY = WIDTH + 1;

	// 2^WIDTH, base for the reciprocal table
	localparam logic [2*WIDTH-1:0] RECIP_ONE = {{(WIDTH-1){1'b0}}, 1'b1, {WIDTH{1'b0}}};

	// ====================
	// enums
	// ====================
	typedef enum logic {
		DIV_IDLE,
		DIV_ITERATE
	} divState_t;

	typedef enum logic [1:0] {
		PATH_ZERO = 2'd0,
		PATH_FAST = 2'd1,
		PATH_SLOW = 2'd2
	} divPath_t;

	// floor(2^WIDTH / divisor) for table entries, zero otherwise
	// divisor one saturates to all ones, still nonzero so it counts as in the table
	function automatic logic [WIDTH-1:0] fastReciprocal(input logic [WIDTH-1:0] divisor);
		logic [2*WIDTH-1:0] scaled;
		case (divisor)
			1: scaled = RECIP_ONE - 1;
			2: scaled = RECIP_ONE / 2;
			3: scaled = RECIP_ONE / 3;
			4: scaled = RECIP_ONE / 4;
			5: scaled = RECIP_ONE / 5;
			6: scaled = RECIP_ONE / 6;
			7: scaled = RECIP_ONE / 7;
			8: scaled = RECIP_ONE / 8;
			9: scaled = RECIP_ONE / 9;
			10: scaled = RECIP_ONE / 10;
			16: scaled = RECIP_ONE / 16;
			64: scaled = RECIP_ONE / 64;
			100: scaled = RECIP_ONE / 100;
			256: scaled = RECIP_ONE / 256;
			1000: scaled = RECIP_ONE / 1000;
			default: scaled = '0;
		endcase
		return scaled[WIDTH-1:0];
	endfunction

endpackage

`default_nettype wire

// ==== source/specialCaseDivider.sv ====
// single-cycle divider for the constant divisors of the reciprocal table
// quotient estimate from a reciprocal multiply
// one-step remainder correction makes the result exact
`default_nettype none

module specialCaseDivider (
	input  logic [divPkg::WIDTH-1:0] dividend,
	input  logic [divPkg::WIDTH-1:0] divisor,
	output logic [divPkg::WIDTH-1:0] quotient,
	output logic [divPkg::WIDTH-1:0] remainder,
	output logic                     handled
);
	import divPkg::*;

	logic [WIDTH-1:0] recip;
	logic [2*WIDTH-1:0] product;
	logic [WIDTH-1:0] qEst;
	logic [WIDTH-1:0] rEst;
	logic dividendZero;
	logic divisorOne;
	logic needFix;

	// ====================
	// estimate
	// ====================
	assign recip = fastReciprocal(divisor);
	// full-width product, upper half is floor(a * m / 2^WIDTH)
	assign product = dividend * recip;
	assign qEst = product[2*WIDTH-1:WIDTH];

	// estimate is q or q-1, so remainder is below 2*divisor
	// and fits the word
	assign rEst = dividend - qEst * divisor;
	assign needFix = (rEst >= divisor);

	assign dividendZero = (dividend == '0);
	assign divisorOne = (divisor == WIDTH'(1));

	// ====================
	// result select
	// ====================
	always_comb begin
		if (dividendZero) begin
			quotient = '0;
			remainder = '0;
		end else if (divisorOne) begin
			// reciprocal of one saturates, pass dividend straight through
			quotient = dividend;
			remainder = '0;
		end else if (needFix) begin
			// estimate one short
			quotient = qEst + 1'b1;
			remainder = rEst - divisor;
		end else begin
			quotient = qEst;
			remainder = rEst;
		end
	end

	// zero dividend needs no table entry
	assign handled = (recip != '0) || dividendZero;

endmodule

`default_nettype wire

// ==== source/serialDivider.sv ====
// radix-2 restoring divider, one quotient bit per cycle
// operands latched on start, done pulses SLOW_LATENCY cycles later
`default_nettype none

module serialDivider (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start,
	input  logic [divPkg::WIDTH-1:0] dividend,
	input  logic [divPkg::WIDTH-1:0] divisor,
	output logic                     done,
	output logic [divPkg::WIDTH-1:0] quotient,
	output logic [divPkg::WIDTH-1:0] remainder
);
	import divPkg::*;

	typedef logic [$clog2(WIDTH+1)-1:0] bitCount_t;

	// bits still to retire, zero when idle
	bitCount_t bitCount;
	logic [WIDTH-1:0] divReg;
	// dividend shifts out the top while quotient bits shift in
	logic [WIDTH-1:0] quoReg;
	logic [WIDTH-1:0] remReg;
	logic [WIDTH:0] partial;
	logic [WIDTH:0] trial;

	// ====================
	// one step
	// ====================
	assign partial = {remReg, quoReg[WIDTH-1]};
	// top bit set means the divisor did not fit
	assign trial = partial - {1'b0, divReg};

	// control
	always_ff @(posedge clk) begin
		if (reset) begin
			bitCount <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				bitCount <= bitCount_t'(WIDTH);
			end else if (bitCount != '0) begin
				bitCount <= bitCount - 1'b1;
				// last bit retires on this edge
				done <= (bitCount == bitCount_t'(1));
			end
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (start) begin
			divReg <= divisor;
			quoReg <= dividend;
			remReg <= '0;
		end else if (bitCount != '0) begin
			if (trial[WIDTH]) begin
				// restore, keep shifted remainder
				remReg <= partial[WIDTH-1:0];
				quoReg <= {quoReg[WIDTH-2:0], 1'b0};
			end else begin
				remReg <= trial[WIDTH-1:0];
				quoReg <= {quoReg[WIDTH-2:0], 1'b1};
			end
		end
	end

	assign quotient = quoReg;
	assign remainder = remReg;

	// a new operand pair would corrupt the running division
	startWhileRunning: assert property (@(posedge clk) disable iff (reset)
		start |-> (bitCount == '0))
		else $error("serialDivider started while running");

endmodule

`default_nettype wire

// ==== source/divIssue.sv ====
// producer side of the division unit
// engine select between zero, constant-divisor and serial paths
// FSM for the serial divider and registered FIFO write port
`default_nettype none

module divIssue (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start,
	input  logic [divPkg::WIDTH-1:0] dividend,
	input  logic [divPkg::WIDTH-1:0] divisor,
	input  logic                     fifoFull,
	output logic                     busy,
	output logic                     fifoPush,
	output logic                     pushDbz,
	output logic [divPkg::WIDTH-1:0] pushQuotient,
	output logic [divPkg::WIDTH-1:0] pushRemainder,
	output divPkg::divPath_t         pushPath
);
	import divPkg::*;

	divState_t state;
	logic accept;
	logic divisorZero;
	logic immediate;
	logic fastHandled;
	logic [WIDTH-1:0] fastQuotient;
	logic [WIDTH-1:0] fastRemainder;
	logic serStart;
	logic serDone;
	logic [WIDTH-1:0] serQuotient;
	logic [WIDTH-1:0] serRemainder;

	// ====================
	// engines
	// ====================
	specialCaseDivider fastDiv (
		.dividend (dividend),
		.divisor  (divisor),
		.quotient (fastQuotient),
		.remainder(fastRemainder),
		.handled  (fastHandled)
	);

	serialDivider slowDiv (
		.clk      (clk),
		.reset    (reset),
		.start    (serStart),
		.dividend (dividend),
		.divisor  (divisor),
		.done     (serDone),
		.quotient (serQuotient),
		.remainder(serRemainder)
	);

	assign divisorZero = (divisor == '0);
	// result ready on the next edge, no serial run
	assign immediate = divisorZero || fastHandled;

	// pending push counts as occupancy, so a request never lands on a full FIFO
	assign busy = (state == DIV_ITERATE) || fifoFull || fifoPush;
	assign accept = start && !busy;
	assign serStart = accept && !immediate;

	// ====================
	// FSM
	// ====================
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= DIV_IDLE;
			fifoPush <= 1'b0;
		end else begin
			fifoPush <= 1'b0;
			case (state)
				DIV_IDLE: begin
					if (accept && immediate) begin
						fifoPush <= 1'b1;
					end else if (serStart) begin
						state <= DIV_ITERATE;
					end
				end
				DIV_ITERATE: begin
					if (serDone) begin
						fifoPush <= 1'b1;
						state <= DIV_IDLE;
					end
				end
			endcase
		end
	end

	// result payload toward the FIFO
	always_ff @(posedge clk) begin
		if (accept && divisorZero) begin
			// flagged result, no trap
			pushQuotient <= '1;
			pushRemainder <= dividend;
			pushDbz <= 1'b1;
			pushPath <= PATH_ZERO;
		end else if (accept && fastHandled) begin
			pushQuotient <= fastQuotient;
			pushRemainder <= fastRemainder;
			pushDbz <= 1'b0;
			pushPath <= PATH_FAST;
		end else if ((state == DIV_ITERATE) && serDone) begin
			pushQuotient <= serQuotient;
			pushRemainder <= serRemainder;
			pushDbz <= 1'b0;
			pushPath <= PATH_SLOW;
		end
	end

	// ====================
	// checks
	// ====================
	startWhileBusy: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy)
		else $error("request raised while busy");

	pushIntoFull: assert property (@(posedge clk) disable iff (reset)
		fifoPush |-> !fifoFull)
		else $error("result pushed into a full FIFO");

	// serial engine finishes exactly on schedule
	slowLatency: assert property (@(posedge clk) disable iff (reset)
		serStart |-> ##SLOW_LATENCY serDone)
		else $error("serial divider missed its latency");

endmodule

`default_nettype wire

// ==== source/resultFifo.sv ====
// in-order result buffer
// circular storage with read and write pointers and an occupancy count
`default_nettype none

module resultFifo (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     push,
	input  logic                     pop,
	input  logic [divPkg::WIDTH-1:0] inQuotient,
	input  logic [divPkg::WIDTH-1:0] inRemainder,
	input  logic                     inDbz,
	input  divPkg::divPath_t         inPath,
	output logic [divPkg::WIDTH-1:0] headQuotient,
	output logic [divPkg::WIDTH-1:0] headRemainder,
	output logic                     headDbz,
	output divPkg::divPath_t         headPath,
	output logic                     full,
	output logic                     empty
);
	import divPkg::*;

	typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(FIFO_DEPTH+1)-1:0] count_t;

	logic [WIDTH-1:0] quotMem [FIFO_DEPTH];
	logic [WIDTH-1:0] remMem [FIFO_DEPTH];
	logic dbzMem [FIFO_DEPTH];
	divPath_t pathMem [FIFO_DEPTH];
	ptr_t wrPtr;
	ptr_t rdPtr;
	count_t count;

	// ====================
	// pointers and count
	// ====================
	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			// simultaneous push and pop leaves count alone
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			quotMem[wrPtr] <= inQuotient;
			remMem[wrPtr] <= inRemainder;
			dbzMem[wrPtr] <= inDbz;
			pathMem[wrPtr] <= inPath;
		end
	end

	// head entry read straight from storage
	assign headQuotient = quotMem[rdPtr];
	assign headRemainder = remMem[rdPtr];
	assign headDbz = dbzMem[rdPtr];
	assign headPath = pathMem[rdPtr];

	assign full = (count == count_t'(FIFO_DEPTH));
	assign empty = (count == '0);

	overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full)
		else $error("resultFifo overflow");

	underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
		else $error("resultFifo underflow");

endmodule

`default_nettype wire

// ==== source/resultDrain.sv ====
// consumer side of the division unit
// pops under the ready level, registers the result outward
// running counts of results and divide-by-zero results
`default_nettype none

module resultDrain (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           resultReady,
	input  logic                           fifoEmpty,
	input  logic [divPkg::WIDTH-1:0]       headQuotient,
	input  logic [divPkg::WIDTH-1:0]       headRemainder,
	input  logic                           headDbz,
	input  divPkg::divPath_t               headPath,
	output logic                           fifoPop,
	output logic                           resultValid,
	output logic                           divByZero,
	output logic [divPkg::WIDTH-1:0]       quotient,
	output logic [divPkg::WIDTH-1:0]       remainder,
	output divPkg::divPath_t               path,
	output logic [divPkg::COUNT_WIDTH-1:0] resultCount,
	output logic [divPkg::COUNT_WIDTH-1:0] dbzCount
);
	import divPkg::*;

	// at most one result per cycle
	assign fifoPop = !fifoEmpty && resultReady;

	// valid pulse and counters
	always_ff @(posedge clk) begin
		if (reset) begin
			resultValid <= 1'b0;
			resultCount <= '0;
			dbzCount <= '0;
		end else begin
			resultValid <= fifoPop;
			// counters wrap at COUNT_WIDTH
			if (fifoPop) begin
				resultCount <= resultCount + 1'b1;
			end
			if (fifoPop && headDbz) begin
				dbzCount <= dbzCount + 1'b1;
			end
		end
	end

	// outward result, held until the next pop
	always_ff @(posedge clk) begin
		if (fifoPop) begin
			quotient <= headQuotient;
			remainder <= headRemainder;
			divByZero <= headDbz;
			path <= headPath;
		end
	end

endmodule

`default_nettype wire

// ==== source/divUnit.sv ====
// top level of the division unit
// producer, result FIFO and consumer
`default_nettype none

module divUnit (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           start,
	input  logic [divPkg::WIDTH-1:0]       dividend,
	input  logic [divPkg::WIDTH-1:0]       divisor,
	input  logic                           resultReady,
	output logic                           busy,
	output logic                           resultValid,
	output logic [divPkg::WIDTH-1:0]       quotient,
	output logic [divPkg::WIDTH-1:0]       remainder,
	output logic                           divByZero,
	output divPkg::divPath_t               path,
	output logic [divPkg::COUNT_WIDTH-1:0] resultCount,
	output logic [divPkg::COUNT_WIDTH-1:0] dbzCount
);
	import divPkg::*;

	// producer to FIFO
	logic fifoPush;
	logic fifoFull;
	logic pushDbz;
	logic [WIDTH-1:0] pushQuotient;
	logic [WIDTH-1:0] pushRemainder;
	divPath_t pushPath;

	// FIFO to consumer
	logic fifoPop;
	logic fifoEmpty;
	logic headDbz;
	logic [WIDTH-1:0] headQuotient;
	logic [WIDTH-1:0] headRemainder;
	divPath_t headPath;

	divIssue issue (
		.clk(clk), .reset(reset), .start(start),
		.dividend(dividend), .divisor(divisor),
		.fifoFull(fifoFull), .busy(busy),
		.fifoPush(fifoPush), .pushDbz(pushDbz),
		.pushQuotient(pushQuotient), .pushRemainder(pushRemainder),
		.pushPath(pushPath)
	);

	resultFifo fifo (
		.clk(clk), .reset(reset), .push(fifoPush), .pop(fifoPop),
		.inQuotient(pushQuotient), .inRemainder(pushRemainder),
		.inDbz(pushDbz), .inPath(pushPath),
		.headQuotient(headQuotient), .headRemainder(headRemainder),
		.headDbz(headDbz), .headPath(headPath),
		.full(fifoFull), .empty(fifoEmpty)
	);

	resultDrain drain (
		.clk(clk), .reset(reset), .resultReady(resultReady),
		.fifoEmpty(fifoEmpty), .headQuotient(headQuotient),
		.headRemainder(headRemainder), .headDbz(headDbz), .headPath(headPath),
		.fifoPop(fifoPop), .resultValid(resultValid), .divByZero(divByZero),
		.quotient(quotient), .remainder(remainder), .path(path),
		.resultCount(resultCount), .dbzCount(dbzCount)
	);

endmodule

`default_nettype wire

// ==== tb/divModel.svh ====
// reference model for the division unit testbench
// expected quotient, remainder, flag and path per operand pair
// queue of outstanding results and request counts
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

// ====================
// expected result
// ====================
typedef struct packed {
	logic [WIDTH-1:0] quotient;
	logic [WIDTH-1:0] remainder;
	logic             dbz;
	divPath_t         path;
} expected_t;

// results in request order
expected_t expectQ[$];
// accepted requests and how many divide by zero
int unsigned issuedCount = 0;
int unsigned issuedDbz = 0;

// divisor covered by the constant-divisor engine
function automatic logic inFastTable(input logic [WIDTH-1:0] b);
	return fastReciprocal(b) != '0;
endfunction

// plain arithmetic reference
function automatic expected_t modelDivide(input logic [WIDTH-1:0] a,
		input logic [WIDTH-1:0] b);
	expected_t e;
	if (b == '0) begin
		// flagged, quotient all ones, dividend kept as remainder
		e.quotient = '1;
		e.remainder = a;
		e.dbz = 1'b1;
		e.path = PATH_ZERO;
	end else begin
		e.quotient = a / b;
		e.remainder = a % b;
		e.dbz = 1'b0;
		// zero dividend never needs the serial engine
		if ((a == '0) || inFastTable(b)) begin
			e.path = PATH_FAST;
		end else begin
			e.path = PATH_SLOW;
		end
	end
	return e;
endfunction

// one accepted request
task automatic recordRequest(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
	expectQ.push_back(modelDivide(a, b));
	issuedCount++;
	if (b == '0) begin
		issuedDbz++;
	end
endtask

`endif

// ==== tb/divUnitTb.sv ====
// testbench for the division unit
// seeded random requests over zero, constant-divisor and serial paths
// model queue, result and counter compares, cycle timeout
`default_nettype none

module divUnitTb;
	timeunit 1ns;
	timeprecision 1ps;
	import divPkg::*;

	`include "divModel.svh"

	localparam int NUM_FAST = 40;
	localparam int NUM_ZERO_DIVIDEND = 8;
	localparam int NUM_SLOW = 20;
	localparam int NUM_DBZ = 8;
	localparam int NUM_MIXED = 60;
	localparam int NUM_REQUESTS = NUM_FAST + NUM_ZERO_DIVIDEND + NUM_SLOW + NUM_DBZ + NUM_MIXED;
	localparam int TIMEOUT_CYCLES = NUM_REQUESTS * (SLOW_LATENCY + 8);
	localparam int FAST_DIVISORS [15] = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 16, 64, 100, 256, 1000};

	logic clk;
	logic reset;
	logic start;
	logic [WIDTH-1:0] dividend;
	logic [WIDTH-1:0] divisor;
	logic resultReady;
	logic busy;
	logic resultValid;
	logic [WIDTH-1:0] quotient;
	logic [WIDTH-1:0] remainder;
	logic divByZero;
	divPath_t path;
	logic [COUNT_WIDTH-1:0] resultCount;
	logic [COUNT_WIDTH-1:0] dbzCount;

	integer stimSeed = 32'h2619;
	// separate stream for the ready level
	integer readySeed = 32'h2619 ^ 32'h5a5a;
	logic stallEnable = 1'b0;
	logic stalled;
	int unsigned deliveredCount = 0;
	int unsigned deliveredDbz = 0;
	int unsigned cycleCount;

	divUnit divUnit_inst (
		.clk(clk), .reset(reset), .start(start),
		.dividend(dividend), .divisor(divisor), .resultReady(resultReady),
		.busy(busy), .resultValid(resultValid),
		.quotient(quotient), .remainder(remainder), .divByZero(divByZero),
		.path(path), .resultCount(resultCount), .dbzCount(dbzCount)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ====================
	// compares
	// ====================
	task automatic stopOnError(input string msg);
		$display("Fail at %0d ns: %s", $time, msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkWord(input string what, input logic [WIDTH-1:0] got,
			input logic [WIDTH-1:0] want);
		if (got !== want) begin
			stopOnError($sformatf("%s is %h, expected %h", what, got, want));
		end
	endtask

	task automatic checkFlag(input string what, input logic got, input logic want);
		if (got !== want) begin
			stopOnError($sformatf("%s is %b, expected %b", what, got, want));
		end
	endtask

	task automatic checkPath(input string what, input divPath_t got, input divPath_t want);
		if (got !== want) begin
			stopOnError($sformatf("%s is %s, expected %s", what, got.name(), want.name()));
		end
	endtask

	task automatic checkCount(input string what, input logic [COUNT_WIDTH-1:0] got,
			input logic [COUNT_WIDTH-1:0] want);
		if (got !== want) begin
			stopOnError($sformatf("%s is %0d, expected %0d", what, got, want));
		end
	endtask

	// ====================
	// stimulus helpers
	// ====================
	// all ones, powers of two and their neighbours, or plain random
	function automatic logic [WIDTH-1:0] pickDividend();
		int unsigned kind;
		int unsigned k;
		logic [WIDTH-1:0] pow;
		kind = $unsigned($random(stimSeed)) % 8;
		k = $unsigned($random(stimSeed)) % WIDTH;
		pow = WIDTH'(1) << k;
		case (kind)
			0: return '1;
			1: return pow;
			2: return pow - 1'b1;
			3: return pow + 1'b1;
			default: return $random(stimSeed);
		endcase
	endfunction

	// random width so small divisors show up too
	function automatic logic [WIDTH-1:0] pickSlowDivisor();
		logic [WIDTH-1:0] d;
		int unsigned bits;
		d = '0;
		while ((d == '0) || inFastTable(d)) begin
			bits = 1 + $unsigned($random(stimSeed)) % WIDTH;
			d = $random(stimSeed);
			d = d >> (WIDTH - bits);
		end
		return d;
	endfunction

	// busy sampled mid-cycle and start held for one edge
	task automatic issueRequest(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
		@(negedge clk);
		while (busy) begin
			@(negedge clk);
		end
		@(posedge clk);
		start <= 1'b1;
		dividend <= a;
		divisor <= b;
		recordRequest(a, b);
		@(posedge clk);
		start <= 1'b0;
	endtask

	// long low stretches of ready when stalls are on
	initial begin
		stalled = 1'b0;
		forever begin
			@(posedge clk);
			if (!stallEnable) begin
				stalled = 1'b0;
			end else if (stalled) begin
				stalled = ($unsigned($random(readySeed)) % 12) != 0;
			end else begin
				stalled = ($unsigned($random(readySeed)) % 16) == 0;
			end
			resultReady <= !stalled;
		end
	end

	// registered outputs sampled mid-cycle
	initial begin
		expected_t want;
		forever begin
			@(negedge clk);
			if (resultValid) begin
				if (expectQ.size() == 0) begin
					stopOnError("result delivered with no request outstanding");
				end else begin
					want = expectQ.pop_front();
					checkWord("quotient", quotient, want.quotient);
					checkWord("remainder", remainder, want.remainder);
					checkFlag("divByZero", divByZero, want.dbz);
					checkPath("path", path, want.path);
					deliveredCount++;
					if (want.dbz) begin
						deliveredDbz++;
					end
					checkCount("resultCount", resultCount, COUNT_WIDTH'(deliveredCount));
					checkCount("dbzCount", dbzCount, COUNT_WIDTH'(deliveredDbz));
				end
			end
		end
	end

	// timeout counted from reset release
	initial begin
		cycleCount = 0;
		wait (reset === 1'b0);
		forever begin
			@(posedge clk);
			cycleCount++;
			if (cycleCount > TIMEOUT_CYCLES) begin
				$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
				$display("*** TEST FAILED ***");
				$fatal(1, "timeout");
			end
		end
	end

	// ====================
	// main sequence
	// ====================
	initial begin
		int i;
		int unsigned kind;
		logic [WIDTH-1:0] b;
		reset = 1'b1;
		start = 1'b0;
		dividend = '0;
		divisor = '0;
		resultReady = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkFlag("busy after reset", busy, 1'b0);
		checkFlag("resultValid after reset", resultValid, 1'b0);
		checkCount("resultCount after reset", resultCount, '0);
		checkCount("dbzCount after reset", dbzCount, '0);

		// table divisors and then zero dividends
		for (i = 0; i < NUM_FAST; i++) begin
			issueRequest(pickDividend(), WIDTH'(FAST_DIVISORS[i % 15]));
		end
		for (i = 0; i < NUM_ZERO_DIVIDEND; i++) begin
			b = $random(stimSeed);
			issueRequest('0, (b == '0) ? WIDTH'(1) : b);
		end
		// serial engine
		for (i = 0; i < NUM_SLOW; i++) begin
			issueRequest(pickDividend(), pickSlowDivisor());
		end
		for (i = 0; i < NUM_DBZ; i++) begin
			issueRequest(pickDividend(), '0);
		end

		// mixed paths under back-pressure
		stallEnable = 1'b1;
		for (i = 0; i < NUM_MIXED; i++) begin
			kind = $unsigned($random(stimSeed)) % 4;
			case (kind)
				0: issueRequest(pickDividend(),
					WIDTH'(FAST_DIVISORS[$unsigned($random(stimSeed)) % 15]));
				1: issueRequest(pickDividend(), pickSlowDivisor());
				2: issueRequest(pickDividend(), '0);
				default: issueRequest('0, pickSlowDivisor());
			endcase
		end
		stallEnable = 1'b0;

		// drain and then watch for stray results
		while (expectQ.size() != 0) begin
			@(negedge clk);
		end
		repeat (8) @(negedge clk);
		checkCount("final resultCount", resultCount, COUNT_WIDTH'(issuedCount));
		checkCount("final dbzCount", dbzCount, COUNT_WIDTH'(issuedDbz));
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+tb
source/divPkg.sv
source/specialCaseDivider.sv
source/serialDivider.sv
source/divIssue.sv
source/resultFifo.sv
source/resultDrain.sv
source/divUnit.sv
tb/divUnitTb.sv

// ==== Bender.yml ====
package:
  name: divUnit

sources:
  - source/divPkg.sv
  - source/specialCaseDivider.sv
  - source/serialDivider.sv
  - source/divIssue.sv
  - source/resultFifo.sv
  - source/resultDrain.sv
  - source/divUnit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/divUnitTb.sv
